// File: all.f
+incdir+logic
logic/midiPkg.sv
logic/audioPkg.sv
logic/synthIfs.sv
logic/midiUartRx.sv
logic/midiParser.sv
logic/synthCsr.sv
logic/sawOscillator.sv
logic/i2sTransmitter.sv
logic/synthBlock.sv
test/tbClock.sv
test/synthBlockTb.sv

// File: logic/audioPkg.sv
// Pitch tables assume a 48 kHz sample rate (sClk 12.288 MHz, 256 cycles per sample)
package audioPkg;

	// Phase increments for notes 120..131, 32-bit phase per sample
	// Lower octaves derived by halving
	localparam logic [31:0] TOP_OCTAVE_INC [12] = '{
		32'd749115490,  // C
		32'd793660205,  // C#
		32'd840853754,  // D
		32'd890853436,  // D#
		32'd943826222,  // E
		32'd999948917,  // F
		32'd1059409159, // F#
		32'd1122404698, // G
		32'd1189146701, // G#
		32'd1259857073, // A
		32'd1334772040, // A#
		32'd1414142141  // B
	};

	// Note number to per-sample phase step
	function automatic logic [31:0] phaseIncrement(input logic [6:0] note);
		logic [3:0] octave;
		logic [3:0] semitone;
		// Octave 10 is the table octave
		octave = 4'(note / 7'd12);
		semitone = 4'(note % 7'd12);
		return TOP_OCTAVE_INC[semitone] >> (4'd10 - octave);
	endfunction

endpackage

// File: logic/i2sTransmitter.sv
// Free running I2S master, 32 BCLK per frame, same 16-bit sample on left and right
`include "synthBlock_defs.svh"

module i2sTransmitter (
	input  logic                    sClk,
	input  logic                    arstN,
	input  logic [`AUDIO_WIDTH-1:0] sample,
	output logic                    i2sMclk,
	output logic                    i2sBclk,
	output logic                    i2sLrclk,
	output logic                    i2sSdata,
	output logic                    sampleReq
);

	localparam int MCLK_BIT = $clog2(`I2S_MCLK_DIV) - 1;
	localparam int BCLK_BIT = $clog2(`I2S_BCLK_DIV) - 1;
	// 32 BCLK periods per frame
	localparam int CNT_W = BCLK_BIT + 6;
	localparam int BIT_W = $clog2(`AUDIO_WIDTH);

	logic [CNT_W-1:0] frameCnt;
	logic [CNT_W-1:0] frameCntNext;
	// BCLK slot about to start
	logic [4:0] slotNext;
	logic [BIT_W-1:0] bitSel;
	logic bclkFall;
	logic [`AUDIO_WIDTH-1:0] holdQ;

	assign frameCntNext = frameCnt + 1'b1;
	assign slotNext = frameCntNext[CNT_W-1 -: 5];
	// MSB one slot after the LRCLK edge, LSB in the first slot of the next half
	assign bitSel = BIT_W'(slotNext - 5'd1);
	assign bclkFall = &frameCnt[BCLK_BIT:0];

	// Clocks straight off counter flops
	assign i2sMclk = frameCnt[MCLK_BIT];
	assign i2sBclk = frameCnt[BCLK_BIT];
	// Low for left
	assign i2sLrclk = frameCnt[CNT_W-1];

	// ----------------------------------------------------------
	// Serializer, data moves on BCLK falling edges
	// ----------------------------------------------------------
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			frameCnt <= '0;
			holdQ <= '0;
			i2sSdata <= 1'b0;
			sampleReq <= 1'b0;
		end
		else
		begin
			frameCnt <= frameCntNext;
			// Frame start drives the old LSB first, then the new sample takes over
			if (bclkFall)
			begin
				i2sSdata <= holdQ[(`AUDIO_WIDTH - 1) - bitSel];
				if (slotNext == 5'd0)
					holdQ <= sample;
			end
			// Cycle after the frame start, also once right after reset
			sampleReq <= (frameCnt == '0);
		end
	end

	// Word select only moves with BCLK falling
	assert property (@(posedge sClk) disable iff (!arstN) $changed(i2sLrclk) |-> $fell(i2sBclk));

endmodule

// File: logic/midiParser.sv
// Note On/Off on one channel only; any other status, real-time included, drops running status
module midiParser (
	input  logic       sClk,
	input  logic       arstN,
	input  logic [7:0] midiData,
	input  logic       midiValid,
	synthCtrlIf.parser ctrl,
	noteIf.source      note
);

	midiPkg::midiByteU rxByte;
	// Running status held, note kind on our channel
	logic runValid;
	logic [2:0] runKind;
	// First data byte seen
	logic haveKey;
	logic [6:0] keyQ;
	logic msgDone;
	logic nextGate;
	logic [6:0] nextNote;
	logic [6:0] nextVelocity;

	assign rxByte = midiPkg::midiByteU'(midiData);
	// Second data byte of a tracked message
	assign msgDone = midiValid && !rxByte.data.marker && runValid && haveKey;

	// ----------------------------------------------------------
	// Note state update
	// ----------------------------------------------------------
	always_comb
	begin
		nextGate = note.gate;
		nextNote = note.note;
		nextVelocity = note.velocity;
		if (msgDone)
		begin
			if (runKind == midiPkg::KIND_NOTE_ON && rxByte.data.value != 7'd0)
			begin
				nextGate = 1'b1;
				nextNote = keyQ;
				nextVelocity = rxByte.data.value;
			end
			// Off releases only the sounding key
			else if (keyQ == note.note)
				nextGate = 1'b0;
		end
	end

	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			runValid <= 1'b0;
			runKind <= midiPkg::KIND_NOTE_OFF;
			haveKey <= 1'b0;
			note.gate <= 1'b0;
			note.note <= '0;
			note.velocity <= '0;
			note.noteEvent <= 1'b0;
		end
		else
		begin
			note.noteEvent <= msgDone &&
				({nextGate, nextNote, nextVelocity} != {note.gate, note.note, note.velocity});
			note.gate <= nextGate;
			note.note <= nextNote;
			note.velocity <= nextVelocity;
			if (midiValid)
			begin
				if (rxByte.status.marker)
				begin
					runValid <= (rxByte.status.kind == midiPkg::KIND_NOTE_OFF ||
						rxByte.status.kind == midiPkg::KIND_NOTE_ON) &&
						(rxByte.status.channel == ctrl.channel);
					runKind <= rxByte.status.kind;
					haveKey <= 1'b0;
				end
				// Data pairs alternate key, velocity
				else if (runValid)
					haveKey <= !haveKey;
			end
		end
	end

	// Key byte
	always_ff @(posedge sClk)
	begin
		if (midiValid && !rxByte.data.marker && runValid && !haveKey)
			keyQ <= rxByte.data.value;
	end

	// Event only right after a received byte
	assert property (@(posedge sClk) disable iff (!arstN) note.noteEvent |-> $past(midiValid));

endmodule

// File: logic/midiPkg.sv
// MIDI byte views and note message kinds; only channel voice Note On/Off are named
package midiPkg;

	// ----------------------------------------------------------
	// One received byte, seen as status or as data
	// ----------------------------------------------------------
	// Top bit set means status byte
	typedef union packed {
		struct packed {
			logic marker;
			// Upper nibble without the marker
			logic [2:0] kind;
			logic [3:0] channel;
		} status;
		struct packed {
			logic marker;
			// Key number or velocity
			logic [6:0] value;
		} data;
	} midiByteU;

	// ----------------------------------------------------------
	// Message kinds, status bits 6:4
	// ----------------------------------------------------------
	// 0x8n
	localparam logic [2:0] KIND_NOTE_OFF = 3'd0;
	// 0x9n, velocity 0 acts as Note Off
	localparam logic [2:0] KIND_NOTE_ON = 3'd1;

endpackage

// File: logic/midiUartRx.sv
// 8N1 receiver, no break or overrun detection; bytes with a low stop bit are dropped
`include "synthBlock_defs.svh"

module midiUartRx (
	input  logic       sClk,
	input  logic       arstN,
	input  logic       midiIn,
	output logic [7:0] midiData,
	output logic       midiValid,
	synthCtrlIf.rx     ctrl
);

	localparam int BIT_CYCLES = `MIDI_BIT_CYCLES;
	localparam int TIMER_W = $clog2(BIT_CYCLES);

	logic [1:0] syncQ;
	logic rxBit;
	logic busy;
	logic [TIMER_W-1:0] bitTimer;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bitIndex;
	logic [7:0] shiftQ;
	logic sampleNow;

	assign rxBit = syncQ[1];
	assign sampleNow = busy && (bitTimer == '0);
	// Counted by the register file
	assign ctrl.rxPulse = midiValid;

	// Two flop synchronizer, line idles high
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
			syncQ <= 2'b11;
		else
			syncQ <= {syncQ[0], midiIn};
	end

	// ----------------------------------------------------------
	// Bit timing
	// ----------------------------------------------------------
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			busy <= 1'b0;
			bitTimer <= '0;
			bitIndex <= '0;
			midiValid <= 1'b0;
		end
		else
		begin
			midiValid <= 1'b0;
			if (!busy)
			begin
				// Start edge; two cycles already lost in the synchronizer
				if (!rxBit)
				begin
					busy <= 1'b1;
					bitTimer <= TIMER_W'(BIT_CYCLES / 2 - 2);
					bitIndex <= '0;
				end
			end
			else if (!sampleNow)
				bitTimer <= bitTimer - 1'b1;
			else
			begin
				bitTimer <= TIMER_W'(BIT_CYCLES - 1);
				bitIndex <= bitIndex + 1'b1;
				// Start bit gone high at mid-bit, treat as glitch
				if (bitIndex == 4'd0 && rxBit)
					busy <= 1'b0;
				else if (bitIndex == 4'd9)
				begin
					busy <= 1'b0;
					// Framing error gives no strobe
					midiValid <= rxBit;
				end
			end
		end
	end

	// Data bits, LSB first
	always_ff @(posedge sClk)
	begin
		if (sampleNow && bitIndex >= 4'd1 && bitIndex <= 4'd8)
			shiftQ <= {rxBit, shiftQ[7:1]};
		if (sampleNow && bitIndex == 4'd9 && rxBit)
			midiData <= shiftQ;
	end

	// Strobe never stretched
	assert property (@(posedge sClk) disable iff (!arstN) midiValid |=> !midiValid);

endmodule

// File: logic/sawOscillator.sv
// Rising saw, one step per sampleReq; phase restarts from 0 whenever sound is off
`include "synthBlock_defs.svh"

module sawOscillator (
	input  logic                    sClk,
	input  logic                    arstN,
	input  logic                    sampleReq,
	noteIf.sink                     note,
	synthCtrlIf.osc                 ctrl,
	output logic [`AUDIO_WIDTH-1:0] sample
);

	logic [31:0] phase;
	logic [31:0] phaseNext;
	// Two's complement view of the phase top
	logic signed [`AUDIO_WIDTH-1:0] phaseTop;
	logic sounding;

	assign sounding = ctrl.enable && note.gate;
	assign phaseNext = phase + audioPkg::phaseIncrement(note.note);
	assign phaseTop = phaseNext[31 -: `AUDIO_WIDTH];

	// ----------------------------------------------------------
	// Phase accumulator and output register
	// ----------------------------------------------------------
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			phase <= '0;
			sample <= '0;
		end
		else if (sampleReq)
		begin
			if (sounding)
			begin
				phase <= phaseNext;
				// Sign kept through the shift
				sample <= phaseTop >>> ctrl.attenuation;
			end
			else
			begin
				// Silence, next note starts at phase 0
				phase <= '0;
				sample <= '0;
			end
		end
	end

endmodule

// File: logic/synthBlock.sv
// Single clock domain, I2S clocks divided from sClk; midiData and midiValid exported for debug
`include "synthBlock_defs.svh"

module synthBlock (
	input  logic        sClk,
	input  logic        arstN,
	// APB slave
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	// MIDI serial in
	input  logic        midiIn,
	// I2S out
	output logic        i2sMclk,
	output logic        i2sBclk,
	output logic        i2sLrclk,
	output logic        i2sSdata,
	// Received byte
	output logic [7:0]  midiData,
	output logic        midiValid
);

	noteIf noteBus ();
	synthCtrlIf ctrlBus ();

	logic [`AUDIO_WIDTH-1:0] sample;
	logic sampleReq;

	// ----------------------------------------------------------
	// Register file
	// ----------------------------------------------------------
	synthCsr i_synthCsr (
		.sClk(sClk), .arstN(arstN),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.ctrl(ctrlBus.csr), .note(noteBus.monitor)
	);

	// ----------------------------------------------------------
	// MIDI receive and note parsing
	// ----------------------------------------------------------
	midiUartRx i_midiUartRx (
		.sClk(sClk), .arstN(arstN), .midiIn(midiIn),
		.midiData(midiData), .midiValid(midiValid), .ctrl(ctrlBus.rx)
	);

	midiParser i_midiParser (
		.sClk(sClk), .arstN(arstN), .midiData(midiData), .midiValid(midiValid),
		.ctrl(ctrlBus.parser), .note(noteBus.source)
	);

	// ----------------------------------------------------------
	// Sound generation and I2S output
	// ----------------------------------------------------------
	// Paced by the transmitter's per-frame request
	sawOscillator i_sawOscillator (
		.sClk(sClk), .arstN(arstN), .sampleReq(sampleReq),
		.note(noteBus.sink), .ctrl(ctrlBus.osc), .sample(sample)
	);

	i2sTransmitter i_i2sTransmitter (
		.sClk(sClk), .arstN(arstN), .sample(sample),
		.i2sMclk(i2sMclk), .i2sBclk(i2sBclk), .i2sLrclk(i2sLrclk), .i2sSdata(i2sSdata),
		.sampleReq(sampleReq)
	);

endmodule

// File: logic/synthBlock_defs.svh
// Shared sizing and addresses; AUDIO_WIDTH must stay 16 and MIDI_BIT_CYCLES at least 4
`ifndef SYNTHBLOCK_DEFS_SVH
`define SYNTHBLOCK_DEFS_SVH

// MIDI serial timing
// sClk cycles per MIDI bit
`define MIDI_BIT_CYCLES 32

// Audio sample width, one sample per I2S half frame
`define AUDIO_WIDTH 16

// I2S clocks as sClk divisions, powers of two
`define I2S_MCLK_DIV 2
`define I2S_BCLK_DIV 8

// APB register map, byte addresses
`define REG_CTRL 8'h00
`define REG_NOTE 8'h04
`define REG_RXCOUNT 8'h08

`endif

// File: logic/synthCsr.sv
// APB slave with zero wait states; only CTRL is writable, other writes and holes error
`include "synthBlock_defs.svh"

module synthCsr (
	input  logic        sClk,
	input  logic        arstN,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	synthCtrlIf.csr     ctrl,
	noteIf.monitor      note
);

	logic access;
	logic mapped;
	logic ctrlWrite;
	// Received byte count that wraps
	logic [15:0] rxCount;

	// Access phase of a transfer
	assign access = psel && penable;
	assign mapped = paddr inside {`REG_CTRL, `REG_NOTE, `REG_RXCOUNT};
	assign ctrlWrite = access && pwrite && (paddr == `REG_CTRL);
	assign pready = 1'b1;
	// Hole, or write to NOTE / RXCOUNT
	assign pslverr = access && (!mapped || (pwrite && paddr != `REG_CTRL));

	// ----------------------------------------------------------
	// CTRL and byte counter
	// ----------------------------------------------------------
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			ctrl.enable <= 1'b0;
			ctrl.channel <= '0;
			ctrl.attenuation <= '0;
			rxCount <= '0;
		end
		else
		begin
			if (ctrlWrite)
			begin
				ctrl.enable <= pwdata[0];
				ctrl.channel <= pwdata[7:4];
				ctrl.attenuation <= pwdata[10:8];
			end
			if (ctrl.rxPulse)
				rxCount <= rxCount + 1'b1;
		end
	end

	// Read mux with NOTE straight from the note bus
	always_comb
	begin
		case (paddr)
			`REG_CTRL:
				prdata = {21'd0, ctrl.attenuation, ctrl.channel, 3'd0, ctrl.enable};
			`REG_NOTE:
				prdata = {15'd0, note.gate, 1'b0, note.note, 1'b0, note.velocity};
			`REG_RXCOUNT:
				prdata = {16'd0, rxCount};
			default:
				prdata = '0;
		endcase
	end

	// APB ordering from the master
	assert property (@(posedge sClk) disable iff (!arstN) penable |-> psel);

endmodule

// File: logic/synthIfs.sv
// Internal buses of the synth block; single sClk domain, no handshake on either
// ----------------------------------------------------------
// Current note, driven by the parser
// ----------------------------------------------------------
interface noteIf;
	// High while a note is held
	logic gate;
	// Last Note On key and velocity
	logic [6:0] note;
	logic [6:0] velocity;
	// One cycle pulse on any change
	logic noteEvent;

	// Parser side
	modport source (output gate, note, velocity, noteEvent);
	// Oscillator side
	modport sink (input gate, note);
	// Register file side
	modport monitor (input gate, note, velocity, noteEvent);
endinterface

// ----------------------------------------------------------
// Control fields from CTRL plus receive strobe
// ----------------------------------------------------------
interface synthCtrlIf;
	logic enable;
	// MIDI channel to listen on
	logic [3:0] channel;
	// Right shift applied to the saw
	logic [2:0] attenuation;
	// Byte received, counted in RXCOUNT
	logic rxPulse;

	modport csr (output enable, channel, attenuation, input rxPulse);
	modport rx (output rxPulse);
	modport parser (input channel);
	modport osc (input enable, attenuation);
endinterface

// File: test/synthBlockTb.sv
// Needs MIDI_BIT_CYCLES and 32 BCLK per frame from the defs header; saw check assumes one note
`include "synthBlock_defs.svh"

module synthBlockTb;

	// sClk cycles per I2S frame
	localparam int FRAME_CYCLES = `I2S_BCLK_DIV * 32;

	logic sClk;
	logic arstN;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic midiIn;
	logic i2sMclk;
	logic i2sBclk;
	logic i2sLrclk;
	logic i2sSdata;
	logic [7:0] midiData;
	logic midiValid;

	integer seed = 49;
	int errorCount = 0;
	int checkCount = 0;
	int timeoutCount = 0;
	// Bytes put on the line and strobes seen
	int sentCount = 0;
	int rxSeen = 0;
	logic [7:0] expectQ[$];

	// I2S capture state with words kept as left/right pairs
	logic [15:0] leftQ[$];
	logic [15:0] rightQ[$];
	int halfQ[$];
	logic [15:0] shiftReg = '0;
	logic [15:0] leftWord = '0;
	logic prevLr = 1'b0;
	logic haveLeft = 1'b0;
	int halfBits = 0;
	// MCLK seen at the previous sClk edge
	logic prevMclk = 1'b0;
	logic mclkArmed = 1'b0;

	tbClock #(.PERIOD(8), .RESET_CYCLES(4)) i_tbClock (.sClk(sClk), .arstN(arstN));

	synthBlock i_synthBlock (
		.sClk(sClk), .arstN(arstN),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.midiIn(midiIn),
		.i2sMclk(i2sMclk), .i2sBclk(i2sBclk), .i2sLrclk(i2sLrclk), .i2sSdata(i2sSdata),
		.midiData(midiData), .midiValid(midiValid)
	);

	// ----------------------------------------------------------
	// Checks and reference model
	// ----------------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("Timeout at %0t while waiting for %s", $time, what);
	endtask

	// Next phase in bits 47:16 and sample of the saw
	function automatic logic [47:0] refStep(input logic [6:0] note, input logic [2:0] atten,
		input logic [31:0] prevPhase);
		logic [31:0] nextPhase;
		logic signed [15:0] top;
		logic signed [15:0] shifted;
		nextPhase = prevPhase + audioPkg::phaseIncrement(note);
		top = nextPhase[31:16];
		shifted = top >>> atten;
		return {nextPhase, shifted};
	endfunction

	function automatic logic [6:0] randNote();
		return 7'($random(seed));
	endfunction

	// Never 0 since that would be a Note Off
	function automatic logic [6:0] randVelocity();
		logic [6:0] v;
		v = 7'($random(seed));
		return (v == 7'd0) ? 7'd1 : v;
	endfunction

	// ----------------------------------------------------------
	// APB master with inputs moving 1 unit after the edge
	// ----------------------------------------------------------
	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge sClk);
		#1;
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge sClk);
		#1;
		penable = 1'b1;
		// Mid access cycle
		#3;
		err = pslverr;
		checkValue("pready", pready, 1);
		@(posedge sClk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge sClk);
		#1;
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge sClk);
		#1;
		penable = 1'b1;
		#3;
		data = prdata;
		err = pslverr;
		checkValue("pready", pready, 1);
		@(posedge sClk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic checkNote(input logic gate, input logic [6:0] key, input logic [6:0] vel);
		logic [31:0] rdata;
		logic err;
		logic [31:0] expected;
		// Gate 16, key 14:8, velocity 6:0
		expected = (32'(gate) << 16) | (32'(key) << 8) | 32'(vel);
		apbRead(`REG_NOTE, rdata, err);
		checkValue("NOTE", rdata, expected);
		checkValue("pslverr on NOTE read", err, 0);
	endtask

	// ----------------------------------------------------------
	// MIDI line in 8N1 format
	// ----------------------------------------------------------
	task automatic sendMidiByte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		expectQ.push_back(b);
		sentCount++;
		for (int i = 0; i < 10; i++)
		begin
			@(posedge sClk);
			#1;
			midiIn = frame[i];
			repeat (`MIDI_BIT_CYCLES - 1) @(posedge sClk);
		end
	endtask

	task automatic waitRxDone();
		int waited;
		waited = 0;
		while (rxSeen != sentCount && waited < 4 * `MIDI_BIT_CYCLES)
		begin
			@(posedge sClk);
			waited++;
		end
		if (rxSeen != sentCount)
			reportTimeout("midiValid of the last byte");
	endtask

	task automatic sendPair(input logic [6:0] d1, input logic [6:0] d2);
		sendMidiByte({1'b0, d1});
		sendMidiByte({1'b0, d2});
		waitRxDone();
	endtask

	task automatic sendMessage(input logic [7:0] status, input logic [6:0] d1, input logic [6:0] d2);
		sendMidiByte(status);
		sendPair(d1, d2);
	endtask

	// Every strobe must match the oldest byte sent
	always @(posedge sClk)
	begin
		if (arstN && midiValid)
		begin
			rxSeen++;
			if (expectQ.size() == 0)
			begin
				errorCount++;
				$display("midiValid pulsed at %0t with no byte on the line", $time);
			end
			else
				checkValue("midiData", midiData, expectQ.pop_front());
		end
	end

	// ----------------------------------------------------------
	// I2S capture
	// ----------------------------------------------------------
	// MCLK is sClk halved so it flips between any two sClk edges
	always @(posedge sClk)
	begin
		if (arstN)
		begin
			if (mclkArmed)
				checkValue("i2sMclk", i2sMclk, !prevMclk);
			mclkArmed = 1'b1;
		end
		prevMclk = i2sMclk;
	end

	// Bit after an LRCLK edge is the LSB of the word before it
	always @(posedge i2sBclk)
	begin
		shiftReg = {shiftReg[14:0], i2sSdata};
		if (i2sLrclk != prevLr)
		begin
			halfQ.push_back(halfBits);
			halfBits = 1;
			if (i2sLrclk)
			begin
				leftWord = shiftReg;
				haveLeft = 1'b1;
			end
			else if (haveLeft)
			begin
				leftQ.push_back(leftWord);
				rightQ.push_back(shiftReg);
				haveLeft = 1'b0;
			end
		end
		else
			halfBits++;
		prevLr = i2sLrclk;
	end

	task automatic clearCapture();
		leftQ.delete();
		rightQ.delete();
		halfQ.delete();
	endtask

	task automatic waitPairs(input int n);
		int waited;
		waited = 0;
		while (leftQ.size() < n && waited < (n + 2) * FRAME_CYCLES)
		begin
			@(posedge sClk);
			waited++;
		end
		if (leftQ.size() < n)
			reportTimeout("captured I2S frames");
	endtask

	// Flush two frames in flight, then expect zeros and 16-bit halves
	task automatic checkSilentFrames(input int n);
		clearCapture();
		waitPairs(2);
		clearCapture();
		waitPairs(n);
		foreach (leftQ[i])
		begin
			checkValue("silent left word", leftQ[i], 0);
			checkValue("silent right word", rightQ[i], 0);
		end
		foreach (halfQ[i])
			checkValue("BCLK periods per LRCLK half", halfQ[i], 16);
	endtask

	task automatic compareSaw(input logic [6:0] note, input logic [2:0] atten);
		int first;
		logic [31:0] phase;
		logic [47:0] step;
		first = -1;
		foreach (leftQ[i])
		begin
			if (first < 0 && leftQ[i] != 16'd0)
				first = i;
		end
		checkCount++;
		assert (first >= 0 && leftQ.size() - first >= 4)
		else
		begin
			errorCount++;
			$display("Too few sawtooth samples captured after Note On at %0t", $time);
		end
		// Phase starts at 0 before the first nonzero sample
		phase = '0;
		for (int i = 0; i < leftQ.size(); i++)
		begin
			if (first >= 0 && i >= first)
			begin
				step = refStep(note, atten, phase);
				phase = step[47:16];
				checkValue("saw left word", leftQ[i], step[15:0]);
				checkValue("saw right word", rightQ[i], step[15:0]);
			end
			else
				checkValue("right word before the note", rightQ[i], 0);
		end
	endtask

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	initial
	begin : stimulus
		logic [31:0] rdata;
		logic err;
		logic [6:0] noteA;
		logic [6:0] noteB;
		logic [6:0] noteC;
		logic [6:0] velA;
		logic [6:0] velB;
		logic [6:0] velC;
		int waited;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		midiIn = 1'b1;
		waited = 0;
		while (arstN !== 1'b1 && waited < 100)
		begin
			@(posedge sClk);
			waited++;
		end
		if (arstN !== 1'b1)
			reportTimeout("reset release");

		// Register access and reset values
		apbRead(`REG_CTRL, rdata, err);
		checkValue("CTRL after reset", rdata, 0);
		checkValue("pslverr on CTRL read", err, 0);
		apbRead(`REG_RXCOUNT, rdata, err);
		checkValue("RXCOUNT after reset", rdata, 0);
		checkNote(1'b0, 7'd0, 7'd0);
		apbWrite(`REG_CTRL, 32'hFFFF_F5A1, err);
		checkValue("pslverr on CTRL write", err, 0);
		apbRead(`REG_CTRL, rdata, err);
		checkValue("CTRL readback", rdata, 32'h0000_05A1);
		apbWrite(`REG_NOTE, 32'h0001_7F7F, err);
		checkValue("pslverr on NOTE write", err, 1);
		apbWrite(`REG_RXCOUNT, 32'h0000_1234, err);
		checkValue("pslverr on RXCOUNT write", err, 1);
		apbRead(8'h0C, rdata, err);
		checkValue("pslverr on unmapped read", err, 1);
		apbWrite(8'h40, 32'hFFFF_FFFF, err);
		checkValue("pslverr on unmapped write", err, 1);
		checkNote(1'b0, 7'd0, 7'd0);

		// Notes on channel 3, sound disabled
		apbWrite(`REG_CTRL, 32'h0000_0030, err);
		noteA = randNote();
		velA = randVelocity();
		sendMessage(8'h93, noteA, velA);
		checkNote(1'b1, noteA, velA);
		checkSilentFrames(4);
		noteB = randNote();
		velB = randVelocity();
		// Running status
		sendPair(noteB, velB);
		checkNote(1'b1, noteB, velB);
		noteC = randNote();
		velC = randVelocity();
		// Other channel ignored
		sendMessage(8'h95, noteC, velC);
		checkNote(1'b1, noteB, velB);
		sendMessage(8'h83, noteB, 7'h40);
		checkNote(1'b0, noteB, velB);
		sendMessage(8'h93, noteC, velC);
		checkNote(1'b1, noteC, velC);
		// Velocity 0 releases
		sendPair(noteC, 7'd0);
		checkNote(1'b0, noteC, velC);

		// Sound enabled, gate low first
		apbWrite(`REG_CTRL, 32'h0000_0031, err);
		checkSilentFrames(4);
		noteA = randNote();
		velA = randVelocity();
		clearCapture();
		sendMessage(8'h93, noteA, velA);
		checkNote(1'b1, noteA, velA);
		waitPairs(16);
		compareSaw(noteA, 3'd0);
		sendMessage(8'h83, noteA, 7'd0);
		checkNote(1'b0, noteA, velA);
		checkSilentFrames(4);

		// Attenuation 2
		apbWrite(`REG_CTRL, 32'h0000_0231, err);
		noteB = randNote();
		velB = randVelocity();
		clearCapture();
		sendMessage(8'h93, noteB, velB);
		checkNote(1'b1, noteB, velB);
		waitPairs(16);
		compareSaw(noteB, 3'd2);
		sendMessage(8'h83, noteB, 7'd0);

		// Random bytes, then the byte counter
		for (int i = 0; i < 12; i++)
			sendMidiByte(8'($random(seed)));
		waitRxDone();
		apbRead(`REG_RXCOUNT, rdata, err);
		checkValue("RXCOUNT", rdata, sentCount);
		checkValue("bytes never strobed", expectQ.size(), 0);

		$display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: test/tbClock.sv
// Free running clock from time 0; reset released 1 time unit after the last reset edge
module tbClock #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic sClk,
	output logic arstN
);

	// Square wave, low first
	initial
	begin
		sClk = 1'b0;
		forever
			#(PERIOD / 2) sClk = ~sClk;
	end

	// Reset held over the first rising edges
	initial
	begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge sClk);
		#1 arstN = 1'b1;
	end

endmodule
